//--- rtl/stream_pkg.sv
package stream_pkg;

    // Width of one producer word.
    localparam int DATA_W = 16;

    // Width of the full source number carried with each output beat.
    // The top bit is the class and is set for the low class.
    // The lower bits are the index within the class.
    localparam int SRC_W = 3;

    // Tagged beat held in the merger buffer and sent on the output channel.
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [SRC_W-1:0]  src;
    } beat_t;

endpackage

//--- rtl/arb_pkg.sv
package arb_pkg;

    // Sources in each class.
    localparam int GROUP_SRCS = 4;

    // Index of a source within its class.
    localparam int PTR_W = $clog2(GROUP_SRCS);

    // High-class beats that may pass in a row while low waits.
    localparam int STARVE_LIMIT = 4;

    // Width of the high-run counter, wide enough to reach the limit.
    localparam int STARVE_W = $clog2(STARVE_LIMIT + 1);

    // Class select in the merger; the encoding matches the top bit of the tag.
    typedef enum logic {
        CLASS_HIGH = 1'b0,
        CLASS_LOW  = 1'b1
    } class_e;

endpackage

//--- rtl/rr_join_arb.sv
`timescale 1ns/1ps

module rr_join_arb
    import stream_pkg::*, arb_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic [GROUP_SRCS-1:0]             req_valid,
    input  logic [GROUP_SRCS-1:0][DATA_W-1:0] req_data,
    output logic [GROUP_SRCS-1:0]             req_ready,
    output logic                              grant_valid,
    output logic [DATA_W-1:0]                 grant_data,
    output logic [PTR_W-1:0]                  grant_idx,
    input  logic                              grant_ready
);

    logic [GROUP_SRCS-1:0]   req_rot;
    logic [GROUP_SRCS-1:0]   grant_rot;
    logic [GROUP_SRCS-1:0]   grant;
    logic [2*GROUP_SRCS-1:0] req_dbl;
    logic [2*GROUP_SRCS-1:0] grant_dbl;
    logic [PTR_W-1:0]        ptr;
    logic [PTR_W-1:0]        ptr_next;
    logic                    xfer;

    // Rotate so that the source at the pointer sits at bit 0.
    assign req_dbl = {req_valid, req_valid} >> ptr;
    assign req_rot = req_dbl[GROUP_SRCS-1:0];

    // Lowest set bit of the rotated vector wins.
    always_comb begin
        grant_rot = '0;
        for (int i = GROUP_SRCS - 1; i >= 0; i--) begin
            if (req_rot[i]) begin
                grant_rot    = '0;
                grant_rot[i] = 1'b1;
            end
        end
    end

    // Rotate the one-hot grant back to source numbering.
    assign grant_dbl = {grant_rot, grant_rot} << ptr;
    assign grant     = grant_dbl[2*GROUP_SRCS-1:GROUP_SRCS];

    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < GROUP_SRCS; i++) begin
            if (grant[i]) begin
                grant_idx = PTR_W'(i);
            end
        end
    end

    assign grant_valid = |grant;
    assign grant_data  = req_data[grant_idx];
    assign req_ready   = grant & {GROUP_SRCS{grant_ready}};

    assign xfer = grant_valid & grant_ready;

    // Next search starts just past the winner, wrapping at the class size.
    always_comb begin
        if (grant_idx == PTR_W'(GROUP_SRCS - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = grant_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ptr <= '0;
        end else if (xfer) begin
            ptr <= ptr_next;
        end
    end

endmodule

//--- rtl/class_merge.sv
`timescale 1ns/1ps

module class_merge
    import stream_pkg::*, arb_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,

    input  logic              hi_valid,
    input  logic [DATA_W-1:0] hi_data,
    input  logic [PTR_W-1:0]  hi_idx,
    output logic              hi_ready,

    input  logic              lo_valid,
    input  logic [DATA_W-1:0] lo_data,
    input  logic [PTR_W-1:0]  lo_idx,
    output logic              lo_ready,

    output logic              out_valid,
    output beat_t             out_beat,
    input  logic              out_ready
);

    class_e              sel_class;
    logic [PTR_W-1:0]    sel_idx;
    logic [DATA_W-1:0]   sel_data;
    logic                starved;
    logic [STARVE_W-1:0] hi_run;

    beat_t               in_beat;
    beat_t               buf_mem [2];
    logic                wr_ptr;
    logic                rd_ptr;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;

    // Low has waited through the allowed run of high beats.
    assign starved = lo_valid && (hi_run == STARVE_W'(STARVE_LIMIT));

    always_comb begin
        if (hi_valid && !starved) begin
            sel_class = CLASS_HIGH;
        end else begin
            sel_class = CLASS_LOW;
        end
    end

    always_comb begin
        if (sel_class == CLASS_HIGH) begin
            sel_idx  = hi_idx;
            sel_data = hi_data;
        end else begin
            sel_idx  = lo_idx;
            sel_data = lo_data;
        end
    end

    // Readies look only at the registered full flag.
    assign hi_ready = !full && hi_valid && (sel_class == CLASS_HIGH);
    assign lo_ready = !full && lo_valid && (sel_class == CLASS_LOW);

    always_comb begin
        in_beat      = '0;
        in_beat.data = sel_data;
        in_beat.src  = {sel_class == CLASS_LOW, sel_idx};
    end

    // Count high accepts made while a low request is pending.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            hi_run <= '0;
        end else if (!lo_valid || lo_ready) begin
            hi_run <= '0;
        end else if (hi_ready) begin
            hi_run <= hi_run + 1'b1;
        end
    end

    assign push = hi_ready | lo_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            // Push and pop together keep one entry, so the flags hold.
            case ({push, pop})
                2'b10: begin
                    empty <= 1'b0;
                    full  <= !empty;
                end
                2'b01: begin
                    full  <= 1'b0;
                    empty <= !full;
                end
                default: begin
                    full  <= full;
                    empty <= empty;
                end
            endcase
        end
    end

    assign out_valid = !empty;
    assign out_beat  = buf_mem[rd_ptr];

endmodule

//--- rtl/prio_stream_join.sv
`timescale 1ns/1ps

module prio_stream_join
    import stream_pkg::*, arb_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic [2*GROUP_SRCS-1:0]             src_valid,
    input  logic [2*GROUP_SRCS-1:0][DATA_W-1:0] src_data,
    output logic [2*GROUP_SRCS-1:0]             src_ready,
    output logic                                out_valid,
    output beat_t                               out_beat,
    input  logic                                out_ready
);

    logic              hi_valid;
    logic [DATA_W-1:0] hi_data;
    logic [PTR_W-1:0]  hi_idx;
    logic              hi_ready;

    logic              lo_valid;
    logic [DATA_W-1:0] lo_data;
    logic [PTR_W-1:0]  lo_idx;
    logic              lo_ready;

    // Lower half of the sources is the high class.
    rr_join_arb u_arb_hi (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid   (src_valid[GROUP_SRCS-1:0]),
        .req_data    (src_data[GROUP_SRCS-1:0]),
        .req_ready   (src_ready[GROUP_SRCS-1:0]),
        .grant_valid (hi_valid),
        .grant_data  (hi_data),
        .grant_idx   (hi_idx),
        .grant_ready (hi_ready)
    );

    rr_join_arb u_arb_lo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid   (src_valid[2*GROUP_SRCS-1:GROUP_SRCS]),
        .req_data    (src_data[2*GROUP_SRCS-1:GROUP_SRCS]),
        .req_ready   (src_ready[2*GROUP_SRCS-1:GROUP_SRCS]),
        .grant_valid (lo_valid),
        .grant_data  (lo_data),
        .grant_idx   (lo_idx),
        .grant_ready (lo_ready)
    );

    class_merge u_merge (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .hi_valid  (hi_valid),
        .hi_data   (hi_data),
        .hi_idx    (hi_idx),
        .hi_ready  (hi_ready),
        .lo_valid  (lo_valid),
        .lo_data   (lo_data),
        .lo_idx    (lo_idx),
        .lo_ready  (lo_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

endmodule

//--- bench/prio_stream_join_asserts.sv
`timescale 1ns/1ps

module prio_stream_join_asserts
    import stream_pkg::*;
(
    input logic  clk_i,
    input logic  rstn_i,
    input logic  hi_ready,
    input logic  lo_ready,
    input logic  out_valid,
    input beat_t out_beat,
    input logic  out_ready
);

    // A stalled output beat holds until the consumer takes it.
    out_stable_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("Output beat changed or dropped while stalled.");

    // Only one class is accepted per cycle.
    one_ready_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(hi_ready && lo_ready))
        else $error("Both classes were given ready in one cycle.");

    reset_empty_a: assert property (@(posedge clk_i)
        !rstn_i |=> !out_valid)
        else $error("Output valid was high in the cycle after reset.");

endmodule

bind class_merge prio_stream_join_asserts u_merge_asserts (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .hi_ready  (hi_ready),
    .lo_ready  (lo_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
);

//--- bench/prio_stream_join_tb.sv
`timescale 1ns/1ps

module prio_stream_join_tb
    import stream_pkg::*, arb_pkg::*;
();

    localparam int NUM_SRCS       = 2 * GROUP_SRCS;
    localparam int NUM_BEATS      = 2000;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                              clk_i;
    logic                              rstn_i;
    logic [NUM_SRCS-1:0]               src_valid;
    logic [NUM_SRCS-1:0][DATA_W-1:0]   src_data;
    logic [NUM_SRCS-1:0]               src_ready;
    logic                              out_valid;
    beat_t                             out_beat;
    logic                              out_ready;

    integer              seed;
    int                  cycle_count = 0;
    int                  raised_count;
    int                  out_count;
    int                  buf_count;
    int                  stall_xfers;
    int                  ptr_hi_m;
    int                  ptr_lo_m;
    int                  hi_run_m;
    logic [NUM_SRCS-1:0] xfer_seen;
    beat_t               exp_q [$];

    prio_stream_join u_prio_stream_join (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .src_valid (src_valid),
        .src_data  (src_data),
        .src_ready (src_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch in %s.", name);
        end
    endtask

    // First requesting source at or after the pointer, or -1 when idle.
    function automatic int first_requester(input logic [GROUP_SRCS-1:0] req, input int ptr);
        int idx;
        first_requester = -1;
        for (int k = GROUP_SRCS - 1; k >= 0; k--) begin
            idx = (ptr + k) % GROUP_SRCS;
            if (req[idx]) begin
                first_requester = idx;
            end
        end
    endfunction

    // A source offers a new word only once its previous one has transferred.
    task automatic drive_sources();
        for (int i = 0; i < NUM_SRCS; i++) begin
            if (!src_valid[i] || xfer_seen[i]) begin
                if (raised_count < NUM_BEATS && ($random(seed) & 1)) begin
                    src_valid[i] = 1'b1;
                    src_data[i]  = DATA_W'($random(seed));
                    raised_count++;
                end else begin
                    src_valid[i] = 1'b0;
                end
            end
        end
    endtask

    // Last quarter of every 64 cycles is a heavy back-pressure phase.
    task automatic drive_out_ready();
        logic heavy;
        heavy = (cycle_count % 64) >= 48;
        if (heavy) begin
            out_ready = (($random(seed) & 7) == 0);
        end else begin
            out_ready = (($random(seed) & 7) != 0);
        end
    endtask

    initial begin
        seed         = 32'h372d_6088;
        rstn_i       = 1'b0;
        src_valid    = '0;
        src_data     = '0;
        out_ready    = 1'b0;
        raised_count = 0;
        out_count    = 0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        forever begin
            @(negedge clk_i);
            drive_sources();
            drive_out_ready();
        end
    end

    always @(posedge clk_i) begin
        logic [GROUP_SRCS-1:0] hi_req;
        logic [GROUP_SRCS-1:0] lo_req;
        logic [NUM_SRCS-1:0]   exp_ready;
        int                    hi_win;
        int                    lo_win;
        logic                  starved;
        logic                  hi_xfer;
        logic                  lo_xfer;
        string                 test_name;
        beat_t                 exp_beat;
        if (!rstn_i) begin
            ptr_hi_m    = 0;
            ptr_lo_m    = 0;
            hi_run_m    = 0;
            buf_count   = 0;
            stall_xfers = 0;
            xfer_seen   = '0;
        end else begin
            hi_req  = src_valid[GROUP_SRCS-1:0];
            lo_req  = src_valid[NUM_SRCS-1:GROUP_SRCS];
            hi_win  = first_requester(hi_req, ptr_hi_m);
            lo_win  = first_requester(lo_req, ptr_lo_m);
            starved = (lo_win >= 0) && (hi_run_m == STARVE_LIMIT);

            if (buf_count == 2) begin
                test_name = "backpressure";
            end else if (hi_win >= 0 && starved) begin
                test_name = "starvation_guard";
            end else if (hi_win >= 0 && lo_win >= 0) begin
                test_name = "priority";
            end else begin
                test_name = "round_robin";
            end

            exp_ready = '0;
            if (buf_count < 2) begin
                if (hi_win >= 0 && !starved) begin
                    exp_ready[hi_win] = 1'b1;
                end else if (lo_win >= 0) begin
                    exp_ready[GROUP_SRCS + lo_win] = 1'b1;
                end
            end
            check_value(test_name, exp_ready, src_ready);
            check_value("out_valid", buf_count > 0, out_valid);

            hi_xfer   = 1'b0;
            lo_xfer   = 1'b0;
            xfer_seen = '0;
            for (int i = 0; i < NUM_SRCS; i++) begin
                if (src_valid[i] && src_ready[i]) begin
                    xfer_seen[i]  = 1'b1;
                    exp_beat.data = src_data[i];
                    exp_beat.src  = SRC_W'(i);
                    exp_q.push_back(exp_beat);
                    if (i < GROUP_SRCS) begin
                        hi_xfer = 1'b1;
                    end else begin
                        lo_xfer = 1'b1;
                    end
                end
            end

            if (hi_xfer) begin
                ptr_hi_m = (hi_win + 1) % GROUP_SRCS;
            end
            if (lo_xfer) begin
                ptr_lo_m = (lo_win + 1) % GROUP_SRCS;
            end
            if (lo_win < 0 || lo_xfer) begin
                hi_run_m = 0;
            end else if (hi_xfer) begin
                hi_run_m++;
            end

            if (out_ready) begin
                stall_xfers = 0;
            end else if (hi_xfer || lo_xfer) begin
                stall_xfers++;
                check_value("backpressure_limit", 1, stall_xfers <= 2);
            end

            buf_count = buf_count + (hi_xfer || lo_xfer) - (out_valid && out_ready);

            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: output beat %0h arrived with no accepted word waiting",
                             out_beat);
                    $display("TESTS FAILED");
                    $fatal(1, "Unexpected output beat.");
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_value("data_order", exp_beat.data, out_beat.data);
                    check_value("source_tag", exp_beat.src, out_beat.src);
                    out_count++;
                end
            end

            if (out_count == NUM_BEATS) begin
                if (exp_q.size() == 0) begin
                    $display("TESTS PASSED");
                    $finish;
                end else begin
                    $display("ERROR: %0d accepted words never reached the output",
                             exp_q.size());
                    $display("TESTS FAILED");
                    $fatal(1, "Words left behind.");
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles with %0d of %0d beats received",
                     cycle_count, out_count, NUM_BEATS);
            $display("TESTS FAILED");
            $fatal(1, "Simulation timed out.");
        end
    end

endmodule

//--- vlog.f
rtl/stream_pkg.sv
rtl/arb_pkg.sv
rtl/rr_join_arb.sv
rtl/class_merge.sv
rtl/prio_stream_join.sv
bench/prio_stream_join_asserts.sv
bench/prio_stream_join_tb.sv
